/* Bender.yml */
package:
  name: katadc_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/katadc_pkg.sv
      - logic/opb_reg_slave.sv
      - logic/adc3wire_serializer.sv
      - logic/adc_clk_rst_ctrl.sv
      - logic/katadc_ctrl_top.sv
  - target: simulation
    files:
      - verif/katadc_chk.sv
      - verif/katadc_tb.sv

/* all.f */
+incdir+logic
logic/katadc_pkg.sv
logic/opb_reg_slave.sv
logic/adc3wire_serializer.sv
logic/adc_clk_rst_ctrl.sv
logic/katadc_ctrl_top.sv
verif/katadc_chk.sv
verif/katadc_tb.sv

/* logic/adc3wire_serializer.sv */
`timescale 1ns/1ps
`include "katadc_params.svh"

module adc3wire_serializer import katadc_pkg::*; (
  input  logic     OPB_Clk,
  input  logic     reset,
  input  adc_cmd_t cmd,
  output logic     cfg_idle,
  output logic     sclk,
  output logic     sdata,
  output logic     strobe
);

  localparam int DIV_W   = `KATADC_CLKDIV_BITS;
  localparam int FRAME_W = `KATADC_FRAME_BITS;

  cfg_state_t         state;
  logic [DIV_W-1:0]   div_cnt;
  logic               div_wrap;
  logic [FRAME_W-1:0] shift_q;
  logic [FRAME_W-1:0] frame;
  logic [4:0]         progress;
  logic               last_bit;

  // eleven zeros, a one, address, data.
  assign frame    = {{(FRAME_W - 21){1'b0}}, 1'b1, cmd.cfg_addr, cmd.cfg_data};
  assign div_wrap = (div_cnt == '1);
  assign last_bit = (progress == 5'(FRAME_W - 1));

  //////////////////////////////////////////////////
  // frame sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      state <= CFG_IDLE;
    end else begin
      case (state)
        CFG_IDLE: begin
          if (cmd.cfg_start) begin
            state <= CFG_CLKWAIT;
          end
        end
        CFG_CLKWAIT: begin
          if (div_wrap) begin
            state <= CFG_DATA;
          end
        end
        CFG_DATA: begin
          if (div_wrap && last_bit) begin
            state <= CFG_FINISH;
          end
        end
        CFG_FINISH: begin
          if (div_wrap) begin
            state <= CFG_IDLE;
          end
        end
        default: begin
          state <= CFG_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // serial clock divider
  //////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk) begin
    if (reset || (state == CFG_IDLE)) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // shift register
  //////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk) begin
    if ((state == CFG_IDLE) && cmd.cfg_start) begin
      shift_q <= frame;  // starts held during clkwait.
    end else if ((state == CFG_DATA) && div_wrap) begin
      shift_q <= shift_q << 1;
    end
    if (state == CFG_CLKWAIT) begin
      progress <= '0;
    end else if ((state == CFG_DATA) && div_wrap) begin
      progress <= progress + 1'b1;
    end
  end

  assign cfg_idle = (state == CFG_IDLE);
  assign sclk     = div_cnt[DIV_W-1];     // rises mid-bit.
  assign sdata    = shift_q[FRAME_W-1];
  assign strobe   = (state != CFG_DATA);  // active low.

endmodule

/* logic/adc_clk_rst_ctrl.sv */
`timescale 1ns/1ps
`include "katadc_params.svh"

module adc_clk_rst_ctrl import katadc_pkg::*; (
  input  logic     OPB_Clk,
  input  logic     reset,
  input  adc_cmd_t cmd,
  input  logic     psdone,
  output logic     adc_reset,
  output logic     dcm_reset,
  output logic     psen,
  output logic     psincdec,
  output logic     ps_done
);

  localparam logic [7:0] STRETCH = 8'(`KATADC_DCM_RST_CYCLES);

  logic [7:0] stretch_cnt;

  //////////////////////////////////////////////////
  // ADC and DCM resets
  //////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      adc_reset   <= 1'b0;
      stretch_cnt <= STRETCH;  // DCM held through power-up.
    end else begin
      adc_reset <= cmd.reset_pulse;
      if (cmd.reset_pulse) begin
        stretch_cnt <= STRETCH;
      end else if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
    end
  end

  assign dcm_reset = (stretch_cnt != '0);

  //////////////////////////////////////////////////
  // phase shift
  //////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      psen     <= 1'b0;
      psincdec <= 1'b0;
      ps_done  <= 1'b0;
    end else begin
      psen     <= cmd.ps_en;
      psincdec <= cmd.ps_incdec;
      if (cmd.ps_en) begin
        ps_done <= 1'b0;  // new step pending.
      end else if (psdone) begin
        ps_done <= 1'b1;
      end
    end
  end

endmodule

/* logic/katadc_ctrl_top.sv */
`timescale 1ns/1ps

module katadc_ctrl_top import katadc_pkg::*; (
  input  logic       OPB_Clk,
  input  logic       reset,
  input  opb_word_t  OPB_ABus,
  input  logic [0:3] OPB_BE,
  input  opb_word_t  OPB_DBus,
  input  logic       OPB_RNW,
  input  logic       OPB_select,
  output opb_word_t  Sl_DBus,
  output logic       Sl_xferAck,

  output logic       adc0_adc3wire_clk,
  output logic       adc0_adc3wire_data,
  output logic       adc0_adc3wire_strobe,
  output logic       adc0_adc_reset,
  output logic       adc0_dcm_reset,
  output logic       adc0_psen,
  output logic       adc0_psincdec,
  input  logic       adc0_psdone,

  output logic       adc1_adc3wire_clk,
  output logic       adc1_adc3wire_data,
  output logic       adc1_adc3wire_strobe,
  output logic       adc1_adc_reset,
  output logic       adc1_dcm_reset,
  output logic       adc1_psen,
  output logic       adc1_psincdec,
  input  logic       adc1_psdone
);

  adc_cmd_t    cmd0;
  adc_cmd_t    cmd1;
  adc_status_t status0;
  adc_status_t status1;
  logic        cfg_idle0;
  logic        cfg_idle1;
  logic        ps_done0;
  logic        ps_done1;

  assign status0 = '{cfg_idle: cfg_idle0, ps_done: ps_done0};
  assign status1 = '{cfg_idle: cfg_idle1, ps_done: ps_done1};

  //////////////////////////////////////////////////
  // OPB register file
  //////////////////////////////////////////////////

  opb_reg_slave u_opb (
    .OPB_Clk    (OPB_Clk),
    .reset      (reset),
    .OPB_ABus   (OPB_ABus),
    .OPB_BE     (OPB_BE),
    .OPB_DBus   (OPB_DBus),
    .OPB_RNW    (OPB_RNW),
    .OPB_select (OPB_select),
    .Sl_DBus    (Sl_DBus),
    .Sl_xferAck (Sl_xferAck),
    .status0    (status0),
    .status1    (status1),
    .cmd0       (cmd0),
    .cmd1       (cmd1)
  );

  //////////////////////////////////////////////////
  // adc0 channel
  //////////////////////////////////////////////////

  adc3wire_serializer u_ser0 (
    .OPB_Clk  (OPB_Clk),
    .reset    (reset),
    .cmd      (cmd0),
    .cfg_idle (cfg_idle0),
    .sclk     (adc0_adc3wire_clk),
    .sdata    (adc0_adc3wire_data),
    .strobe   (adc0_adc3wire_strobe)
  );

  adc_clk_rst_ctrl u_pin0 (
    .OPB_Clk   (OPB_Clk),
    .reset     (reset),
    .cmd       (cmd0),
    .psdone    (adc0_psdone),
    .adc_reset (adc0_adc_reset),
    .dcm_reset (adc0_dcm_reset),
    .psen      (adc0_psen),
    .psincdec  (adc0_psincdec),
    .ps_done   (ps_done0)
  );

  //////////////////////////////////////////////////
  // adc1 channel
  //////////////////////////////////////////////////

  adc3wire_serializer u_ser1 (
    .OPB_Clk  (OPB_Clk),
    .reset    (reset),
    .cmd      (cmd1),
    .cfg_idle (cfg_idle1),
    .sclk     (adc1_adc3wire_clk),
    .sdata    (adc1_adc3wire_data),
    .strobe   (adc1_adc3wire_strobe)
  );

  adc_clk_rst_ctrl u_pin1 (
    .OPB_Clk   (OPB_Clk),
    .reset     (reset),
    .cmd       (cmd1),
    .psdone    (adc1_psdone),
    .adc_reset (adc1_adc_reset),
    .dcm_reset (adc1_dcm_reset),
    .psen      (adc1_psen),
    .psincdec  (adc1_psincdec),
    .ps_done   (ps_done1)
  );

endmodule

/* logic/katadc_params.svh */
`ifndef KATADC_PARAMS_SVH
`define KATADC_PARAMS_SVH

//////////////////////////////////////////////////
// OPB address window
//////////////////////////////////////////////////
`define KATADC_BASEADDR 32'h0001_0000
`define KATADC_HIGHADDR 32'h0001_FFFF

//////////////////////////////////////////////////
// three-wire serial link
//////////////////////////////////////////////////
`define KATADC_CLKDIV_BITS 4     // 16 OPB cycles per serial bit.
`define KATADC_FRAME_BITS 32

//////////////////////////////////////////////////
// DCM reset stretch
//////////////////////////////////////////////////
`define KATADC_DCM_RST_CYCLES 255  // fits the 8-bit stretch counter.

`endif

/* logic/katadc_pkg.sv */
package katadc_pkg;

  //////////////////////////////////////////////////
  // bus and register widths
  //////////////////////////////////////////////////

  // OPB numbering puts the msb at bit 0.
  typedef logic [0:31] opb_word_t;

  typedef logic [3:0]  cfg_addr_t;  // ADC register address.
  typedef logic [15:0] cfg_data_t;  // ADC register value.

  //////////////////////////////////////////////////
  // per-channel command and status
  //////////////////////////////////////////////////

  // reset_pulse, ps_en and cfg_start are one-cycle strobes.
  typedef struct packed {
    logic      reset_pulse;
    logic      ps_en;
    logic      ps_incdec;
    logic      cfg_start;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
  } adc_cmd_t;

  typedef struct packed {
    logic cfg_idle;
    logic ps_done;
  } adc_status_t;

  // serializer states.
  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_CLKWAIT,
    CFG_DATA,
    CFG_FINISH
  } cfg_state_t;

endpackage

/* logic/opb_reg_slave.sv */
`timescale 1ns/1ps
`include "katadc_params.svh"

module opb_reg_slave import katadc_pkg::*; (
  input  logic        OPB_Clk,
  input  logic        reset,
  input  opb_word_t   OPB_ABus,
  input  logic [0:3]  OPB_BE,
  input  opb_word_t   OPB_DBus,
  input  logic        OPB_RNW,
  input  logic        OPB_select,
  output opb_word_t   Sl_DBus,
  output logic        Sl_xferAck,
  input  adc_status_t status0,
  input  adc_status_t status1,
  output adc_cmd_t    cmd0,
  output adc_cmd_t    cmd1
);

  opb_word_t   offset;
  logic [1:0]  word_sel;
  logic        addr_hit;
  logic        accept;
  logic        wr_en;
  logic        ack_q;

  // index 0 is adc0, index 1 is adc1.
  logic [1:0]  rst_pulse_q;
  logic [1:0]  ps_en_q;
  logic [1:0]  ps_incdec_q;
  logic [1:0]  start_q;
  cfg_addr_t   cfg_addr_q [2];
  cfg_data_t   cfg_data_q [2];

  opb_word_t   rd_word;

  //////////////////////////////////////////////////
  // decode and acknowledge
  //////////////////////////////////////////////////

  assign offset   = OPB_ABus - `KATADC_BASEADDR;
  assign word_sel = offset[28:29];  // byte address bits 3..2.
  assign addr_hit = (OPB_ABus >= `KATADC_BASEADDR) && (OPB_ABus <= `KATADC_HIGHADDR);

  // no accept in the ack cycle, so a held select repeats every other cycle.
  assign accept = OPB_select && addr_hit && !ack_q;
  assign wr_en  = accept && !OPB_RNW;

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      ack_q       <= 1'b0;
      rst_pulse_q <= '0;
      ps_en_q     <= '0;
      start_q     <= '0;
      ps_incdec_q <= '0;
    end else begin
      ack_q       <= accept;
      rst_pulse_q <= '0;  // strobes last one cycle.
      ps_en_q     <= '0;
      start_q     <= '0;
      if (wr_en && (word_sel == 2'd0)) begin
        if (OPB_BE[3]) begin
          rst_pulse_q <= {OPB_DBus[30], OPB_DBus[31]};
        end
        if (OPB_BE[1]) begin
          ps_en_q     <= {OPB_DBus[11], OPB_DBus[15]};
          ps_incdec_q <= {OPB_DBus[10], OPB_DBus[14]};
        end
      end
      for (int ch = 0; ch < 2; ch++) begin
        if (wr_en && OPB_BE[3] && (word_sel == 2'(ch + 1))) begin
          start_q[ch] <= OPB_DBus[31];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // configuration address and data
  //////////////////////////////////////////////////

  always_ff @(posedge OPB_Clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      if (wr_en && (word_sel == 2'(ch + 1))) begin
        if (OPB_BE[2]) begin
          cfg_addr_q[ch] <= OPB_DBus[20:23];
        end
        if (OPB_BE[1]) begin
          cfg_data_q[ch][7:0] <= OPB_DBus[8:15];
        end
        if (OPB_BE[0]) begin
          cfg_data_q[ch][15:8] <= OPB_DBus[0:7];  // high byte.
        end
      end
    end
  end

  assign cmd0 = '{
    reset_pulse: rst_pulse_q[0],
    ps_en:       ps_en_q[0],
    ps_incdec:   ps_incdec_q[0],
    cfg_start:   start_q[0],
    cfg_addr:    cfg_addr_q[0],
    cfg_data:    cfg_data_q[0]
  };

  assign cmd1 = '{
    reset_pulse: rst_pulse_q[1],
    ps_en:       ps_en_q[1],
    ps_incdec:   ps_incdec_q[1],
    cfg_start:   start_q[1],
    cfg_addr:    cfg_addr_q[1],
    cfg_data:    cfg_data_q[1]
  };

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_comb begin
    case (word_sel)
      2'd0: rd_word = {10'b0, ps_incdec_q[1], ps_en_q[1], 2'b0,
                       ps_incdec_q[0], ps_en_q[0], 12'b0,
                       status0.ps_done, status1.ps_done, 2'b0};
      2'd1: rd_word = {cfg_data_q[0], 4'b0, cfg_addr_q[0], 7'b0, status0.cfg_idle};
      2'd2: rd_word = {cfg_data_q[1], 4'b0, cfg_addr_q[1], 7'b0, status1.cfg_idle};
      default: rd_word = '0;
    endcase
  end

  // bus is wired-or, so drive zero outside a read ack.
  assign Sl_DBus    = (ack_q && OPB_RNW) ? rd_word : '0;
  assign Sl_xferAck = ack_q;

endmodule

/* verif/katadc_chk.sv */
`timescale 1ns/1ps

module katadc_chk (
  input logic OPB_Clk,
  input logic reset,
  input logic Sl_xferAck,
  input logic strobe0,
  input logic strobe1,
  input logic cfg_idle0,
  input logic cfg_idle1,
  input logic rst_pulse0,
  input logic rst_pulse1,
  input logic dcm_reset0,
  input logic dcm_reset1
);

  int fails = 0;

  //////////////////////////////////////////////////
  // OPB acknowledge
  //////////////////////////////////////////////////

  ack_single: assert property (@(posedge OPB_Clk) disable iff (reset)
    Sl_xferAck |=> !Sl_xferAck)
    else begin
      fails++;
      $error("Sl_xferAck held high for two cycles");
    end

  //////////////////////////////////////////////////
  // strobe only while busy
  //////////////////////////////////////////////////

  strobe_busy0: assert property (@(posedge OPB_Clk) disable iff (reset)
    !(!strobe0 && cfg_idle0))
    else begin
      fails++;
      $error("adc0 strobe low while idle");
    end

  strobe_busy1: assert property (@(posedge OPB_Clk) disable iff (reset)
    !(!strobe1 && cfg_idle1))
    else begin
      fails++;
      $error("adc1 strobe low while idle");
    end

  //////////////////////////////////////////////////
  // DCM reset stretch
  //////////////////////////////////////////////////

  dcm_len0: assert property (@(posedge OPB_Clk) disable iff (reset)
    rst_pulse0 |=> dcm_reset0 [*255] ##1 !dcm_reset0)
    else begin
      fails++;
      $error("adc0 dcm_reset stretch length wrong");
    end

  dcm_len1: assert property (@(posedge OPB_Clk) disable iff (reset)
    rst_pulse1 |=> dcm_reset1 [*255] ##1 !dcm_reset1)
    else begin
      fails++;
      $error("adc1 dcm_reset stretch length wrong");
    end

endmodule

/* verif/katadc_tb.sv */
`timescale 1ns/1ps
`include "katadc_params.svh"

module katadc_tb import katadc_pkg::*; ();

  typedef struct packed {
    logic        rd;     // 1 read, 0 write.
    logic [1:0]  word;
    logic [3:0]  be;     // BE0 in the msb down to BE3.
    logic [31:0] wdata;
    logic [31:0] exp;
  } stim_row_t;

  localparam logic [31:0] BASE = `KATADC_BASEADDR;
  localparam int MAX_ROWS = 16;
  localparam int LIMIT = MAX_ROWS * 12 + 3 * 600 + 4 * 300 + 1000;

  logic        OPB_Clk;
  logic        reset;
  opb_word_t   OPB_ABus;
  logic [0:3]  OPB_BE;
  opb_word_t   OPB_DBus;
  logic        OPB_RNW;
  logic        OPB_select;
  opb_word_t   Sl_DBus;
  logic        Sl_xferAck;
  logic [1:0]  a_clk, a_data, a_strobe, a_rst, a_dcm, a_psen, a_psincdec, a_psdone;

  int          errors = 0;
  int          cyc = 0;
  int          seed = 79;
  stim_row_t   stim_rows[$];
  logic [31:0] shift0, shift1, frame0, frame1;
  int          frames0 = 0;
  int          frames1 = 0;
  int          psen_cnt[2] = '{0, 0};
  int          arst_cnt[2] = '{0, 0};

  katadc_ctrl_top UUT (
    .OPB_Clk(OPB_Clk), .reset(reset), .OPB_ABus(OPB_ABus), .OPB_BE(OPB_BE),
    .OPB_DBus(OPB_DBus), .OPB_RNW(OPB_RNW), .OPB_select(OPB_select),
    .Sl_DBus(Sl_DBus), .Sl_xferAck(Sl_xferAck),
    .adc0_adc3wire_clk(a_clk[0]), .adc0_adc3wire_data(a_data[0]),
    .adc0_adc3wire_strobe(a_strobe[0]), .adc0_adc_reset(a_rst[0]),
    .adc0_dcm_reset(a_dcm[0]), .adc0_psen(a_psen[0]),
    .adc0_psincdec(a_psincdec[0]), .adc0_psdone(a_psdone[0]),
    .adc1_adc3wire_clk(a_clk[1]), .adc1_adc3wire_data(a_data[1]),
    .adc1_adc3wire_strobe(a_strobe[1]), .adc1_adc_reset(a_rst[1]),
    .adc1_dcm_reset(a_dcm[1]), .adc1_psen(a_psen[1]),
    .adc1_psincdec(a_psincdec[1]), .adc1_psdone(a_psdone[1])
  );

  bind katadc_ctrl_top katadc_chk u_chk (
    .OPB_Clk(OPB_Clk), .reset(reset), .Sl_xferAck(Sl_xferAck),
    .strobe0(adc0_adc3wire_strobe), .strobe1(adc1_adc3wire_strobe),
    .cfg_idle0(cfg_idle0), .cfg_idle1(cfg_idle1),
    .rst_pulse0(cmd0.reset_pulse), .rst_pulse1(cmd1.reset_pulse),
    .dcm_reset0(adc0_dcm_reset), .dcm_reset1(adc1_dcm_reset)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #4 OPB_Clk = ~OPB_Clk;
  end

  always @(posedge OPB_Clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: run exceeded %0d cycles", LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  // pulse counters sample away from the active edge.
  always @(negedge OPB_Clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      if (a_psen[ch] === 1'b1) psen_cnt[ch]++;
      if (a_rst[ch] === 1'b1) arst_cnt[ch]++;
    end
  end

  //////////////////////////////////////////////////
  // frame monitors
  //////////////////////////////////////////////////

  always @(posedge a_clk[0]) if (!a_strobe[0]) shift0 <= {shift0[30:0], a_data[0]};
  always @(posedge a_clk[1]) if (!a_strobe[1]) shift1 <= {shift1[30:0], a_data[1]};

  always @(posedge a_strobe[0]) begin
    if (!reset) begin
      frame0 = shift0;  // end of data phase.
      frames0++;
    end
  end

  always @(posedge a_strobe[1]) begin
    if (!reset) begin
      frame1 = shift1;
      frames1++;
    end
  end

  //////////////////////////////////////////////////
  // bus access
  //////////////////////////////////////////////////

  task automatic bus_xfer(input logic rd, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, input int max_wait,
                          output logic [31:0] rdata, output logic acked);
    int n;
    @(posedge OPB_Clk);
    #1;
    OPB_ABus   = addr;
    OPB_BE     = be;
    OPB_DBus   = rd ? 32'h0 : wdata;
    OPB_RNW    = rd;
    OPB_select = 1'b1;
    n     = 0;
    acked = 1'b0;
    while (!acked && n < max_wait) begin
      @(posedge OPB_Clk);
      #1;
      n++;
      acked = Sl_xferAck;
    end
    rdata      = Sl_DBus;
    OPB_select = 1'b0;
    OPB_RNW    = 1'b0;
    OPB_BE     = 4'b0;
    OPB_DBus   = 32'h0;
  endtask

  task automatic write_word(input logic [1:0] word, input logic [3:0] be,
                            input logic [31:0] data);
    logic [31:0] unused;
    logic        acked;
    bus_xfer(1'b0, BASE + 4 * word, be, data, 16, unused, acked);
    if (!acked) begin
      $display("no acknowledge for a write to word %0d at %0t", word, $time);
      errors++;
    end
  endtask

  task automatic read_word(input logic [1:0] word, output logic [31:0] data);
    logic acked;
    bus_xfer(1'b1, BASE + 4 * word, 4'b1111, 32'h0, 16, data, acked);
    if (!acked) begin
      $display("no acknowledge for a read of word %0d at %0t", word, $time);
      errors++;
    end
  endtask

  task automatic expect_val(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("** Error @%0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // counts cycles of dcm_reset high on each channel, starting now.
  task automatic count_dcm(output int n0, output int n1);
    int guard;
    n0 = 0;
    n1 = 0;
    guard = 0;
    while ((a_dcm[0] || a_dcm[1]) && guard < 400) begin
      if (a_dcm[0]) n0++;
      if (a_dcm[1]) n1++;
      @(posedge OPB_Clk);
      #1;
      guard++;
    end
  endtask

  function automatic logic [31:0] cfg_word(input logic [3:0] a, input logic [15:0] d,
                                           input logic flag);
    return {d, 4'h0, a, 7'h0, flag};
  endfunction

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] rw;
    logic        acked;
    logic [3:0]  a0, a1;
    logic [15:0] d0, d1;
    int          n0, n1, t_start, d, polls, f0, f1, p0, p1, r0, r1;

    reset      = 1'b1;
    OPB_ABus   = '0;
    OPB_BE     = '0;
    OPB_DBus   = '0;
    OPB_RNW    = 1'b0;
    OPB_select = 1'b0;
    a_psdone   = 2'b00;
    repeat (10) @(posedge OPB_Clk);
    #1;
    reset = 1'b0;

    count_dcm(n0, n1);  // stretch after system reset.
    expect_val(n0, 255, "adc0 dcm_reset cycles after reset");
    expect_val(n1, 255, "adc1 dcm_reset cycles after reset");

    // register readback table.
    rw = $random(seed);
    a1 = rw[3:0];
    d1 = rw[31:16];
    rw = $random(seed);
    a0 = rw[3:0];
    d0 = rw[31:16];
    stim_rows.push_back('{1'b0, 2'd1, 4'b0110, 32'h0034_0500, 32'h0});
    stim_rows.push_back('{1'b0, 2'd1, 4'b1000, 32'h1200_0000, 32'h0});
    stim_rows.push_back('{1'b1, 2'd1, 4'b1111, 32'h0, 32'h1234_0501});
    stim_rows.push_back('{1'b0, 2'd2, 4'b1111, cfg_word(a1, d1, 1'b0), 32'h0});
    stim_rows.push_back('{1'b1, 2'd2, 4'b1111, 32'h0, cfg_word(a1, d1, 1'b1)});
    stim_rows.push_back('{1'b0, 2'd1, 4'b1110, cfg_word(a0, d0, 1'b0), 32'h0});
    stim_rows.push_back('{1'b1, 2'd1, 4'b1111, 32'h0, cfg_word(a0, d0, 1'b1)});
    stim_rows.push_back('{1'b1, 2'd3, 4'b1111, 32'h0, 32'h0});
    stim_rows.push_back('{1'b0, 2'd0, 4'b0100, 32'h0002_0000, 32'h0});
    stim_rows.push_back('{1'b1, 2'd0, 4'b1111, 32'h0, 32'h0002_0000});
    foreach (stim_rows[i]) begin
      if (stim_rows[i].rd) begin
        read_word(stim_rows[i].word, rd);
        expect_val(rd, stim_rows[i].exp, $sformatf("table row %0d", i));
      end else begin
        write_word(stim_rows[i].word, stim_rows[i].be, stim_rows[i].wdata);
      end
    end

    bus_xfer(1'b1, `KATADC_HIGHADDR + 32'd1, 4'b1111, 32'h0, 4, rd, acked);
    if (acked) begin
      $display("access outside the address window was acknowledged at %0t", $time);
      errors++;
    end

    // both frames together, with a repeated start on adc0.
    f0 = frames0;
    f1 = frames1;
    write_word(2'd2, 4'b1111, cfg_word(a1, d1, 1'b1));
    write_word(2'd1, 4'b1111, cfg_word(a0, d0, 1'b1));
    t_start = cyc;
    read_word(2'd1, rd);
    expect_val(rd, cfg_word(a0, d0, 1'b0), "word 1 while busy");
    repeat (100) @(posedge OPB_Clk);
    write_word(2'd1, 4'b0001, 32'h0000_0001);
    polls = 0;
    rd = 32'h0;
    while (!rd[0] && polls < 400) begin
      read_word(2'd1, rd);
      polls++;
    end
    d = cyc - t_start;
    if (d < 545 || d > 546) begin
      $display("** Error @%0t: idle returned %0d cycles after start ack", $time, d);
      errors++;
    end
    repeat (40) @(posedge OPB_Clk);
    expect_val(frames0 - f0, 1, "adc0 frame count");
    expect_val(frames1 - f1, 1, "adc1 frame count");
    expect_val(frame0, {11'b0, 1'b1, a0, d0}, "adc0 frame");
    expect_val(frame1, {11'b0, 1'b1, a1, d1}, "adc1 frame");

    // per-ADC reset.
    r0 = arst_cnt[0];
    r1 = arst_cnt[1];
    write_word(2'd0, 4'b0001, 32'h0000_0001);
    @(posedge OPB_Clk);
    #1;
    count_dcm(n0, n1);
    expect_val(arst_cnt[0] - r0, 1, "adc0 adc_reset pulse cycles");
    expect_val(arst_cnt[1] - r1, 0, "adc1 adc_reset pulse cycles");
    expect_val(n0, 255, "adc0 dcm_reset cycles after pulse");
    expect_val(n1, 0, "adc1 dcm_reset cycles after adc0 pulse");

    r0 = arst_cnt[0];
    r1 = arst_cnt[1];
    write_word(2'd0, 4'b0001, 32'h0000_0002);
    @(posedge OPB_Clk);
    #1;
    count_dcm(n0, n1);
    expect_val(arst_cnt[0] - r0, 0, "adc0 adc_reset pulse cycles after adc1 reset");
    expect_val(arst_cnt[1] - r1, 1, "adc1 adc_reset pulse cycles after adc1 reset");
    expect_val(n0, 0, "adc0 dcm_reset cycles after adc1 pulse");
    expect_val(n1, 255, "adc1 dcm_reset cycles after pulse");

    // phase shift on adc0 then adc1.
    p0 = psen_cnt[0];
    p1 = psen_cnt[1];
    write_word(2'd0, 4'b0100, 32'h0001_0000);
    repeat (4) @(posedge OPB_Clk);
    #1;
    expect_val(psen_cnt[0] - p0, 1, "adc0 psen cycles");
    expect_val(psen_cnt[1] - p1, 0, "adc1 psen cycles");
    expect_val(a_psincdec[0], 1'b0, "adc0 psincdec");
    a_psdone[0] = 1'b1;
    @(posedge OPB_Clk);
    #1;
    a_psdone[0] = 1'b0;
    read_word(2'd0, rd);
    expect_val(rd, 32'h0000_0008, "word 0 after adc0 psdone");
    write_word(2'd0, 4'b0100, 32'h0031_0000);
    repeat (4) @(posedge OPB_Clk);
    #1;
    expect_val(psen_cnt[0] - p0, 2, "adc0 psen cycles, second step");
    expect_val(psen_cnt[1] - p1, 1, "adc1 psen cycles");
    expect_val(a_psincdec[1], 1'b1, "adc1 psincdec");
    read_word(2'd0, rd);
    expect_val(rd, 32'h0020_0000, "word 0 after psen clears done");
    a_psdone[1] = 1'b1;
    @(posedge OPB_Clk);
    #1;
    a_psdone[1] = 1'b0;
    read_word(2'd0, rd);
    expect_val(rd, 32'h0020_0004, "word 0 after adc1 psdone");

    $display("errors: %0d (check failures %0d, assertion failures %0d)",
             errors + UUT.u_chk.fails, errors, UUT.u_chk.fails);
    if (errors == 0 && UUT.u_chk.fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
